/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal -f tb.f --top-module tb_synth_top -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* src/adsr_envelope.sv */
`timescale 1ns/1ps
`default_nettype none

`include "synth_config.svh"

module adsr_envelope (
    input wire logic clk_100mhz,
    input wire logic sys_rst,
    input wire synth_pkg::key_event_t key_event,
    output synth_pkg::env_t envelope,
    output logic sounding
);

    import synth_pkg::*;

    env_state_e state;

    ////////////////////
    // linear segments, saturating at both ends
    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            state <= ENV_IDLE;
            envelope <= '0;
        end else if (key_event.trigger) begin
            // retrigger restarts attack from the present level
            state <= ENV_ATTACK;
        end else begin
            case (state)
                ENV_ATTACK: begin
                    if (!key_event.gate) begin
                        state <= ENV_RELEASE;
                    end else if (envelope >= `SYN_ENV_MAX - `SYN_ATTACK_STEP) begin
                        envelope <= `SYN_ENV_MAX;
                        state <= ENV_DECAY;
                    end else begin
                        envelope <= env_t'(envelope + `SYN_ATTACK_STEP);
                    end
                end
                ENV_DECAY: begin
                    if (!key_event.gate) begin
                        state <= ENV_RELEASE;
                    end else if (envelope <= `SYN_SUSTAIN_LEVEL + `SYN_DECAY_STEP) begin
                        envelope <= `SYN_SUSTAIN_LEVEL;
                        state <= ENV_SUSTAIN;
                    end else begin
                        envelope <= env_t'(envelope - `SYN_DECAY_STEP);
                    end
                end
                ENV_SUSTAIN: begin
                    // hold while the key is down
                    if (!key_event.gate) begin
                        state <= ENV_RELEASE;
                    end
                end
                ENV_RELEASE: begin
                    if (envelope <= `SYN_RELEASE_STEP) begin
                        envelope <= '0;
                        state <= ENV_IDLE;
                    end else begin
                        envelope <= env_t'(envelope - `SYN_RELEASE_STEP);
                    end
                end
                default: begin
                    state <= ENV_IDLE;
                end
            endcase
        end
    end

    assign sounding = (state != ENV_IDLE);

    // attack only climbs and never wraps past the peak
    assert property (@(posedge clk_100mhz) disable iff (sys_rst)
        (state == ENV_ATTACK) |=>
            (envelope >= $past(envelope)) && (envelope <= `SYN_ENV_MAX));

endmodule

`default_nettype wire

/* src/mix_pkg.sv */
`default_nettype none

`include "synth_config.svh"

package mix_pkg;

    // unsigned audio sample, midscale is silence for a single voice
    typedef logic [`SYN_SAMPLE_W-1:0] sample_t;

    // 0..NUM_NOTES sounding voices
    typedef logic [$clog2(`SYN_NUM_NOTES+1)-1:0] voice_count_t;

    typedef struct packed {
        voice_count_t voice_count;
        sample_t sample;
    } mix_status_t;

    // approx 256/count, too many voices mutes the mix
    function automatic logic [7:0] recip_factor(input voice_count_t count);
        if (count > `SYN_MAX_NORM_VOICES) begin
            return 8'd0;
        end
        case (count)
            1: return 8'd255;
            2: return 8'd128;
            3: return 8'd85;
            4: return 8'd64;
            5: return 8'd51;
            6: return 8'd42;
            7: return 8'd36;
            8: return 8'd32;
            default: return 8'd0;
        endcase
    endfunction

endpackage

`default_nettype wire

/* src/note_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "synth_config.svh"

module note_decoder (
    input wire logic clk_100mhz,
    input wire logic sys_rst,
    input wire synth_pkg::key_mask_t touch_status,
    output synth_pkg::key_event_t key_events [`SYN_NUM_NOTES]
);

    import synth_pkg::*;

    // current and previous key levels
    key_mask_t key_q;
    key_mask_t key_prev;

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            key_q <= '0;
            key_prev <= '0;
        end else begin
            key_q <= touch_status;
            key_prev <= key_q;
        end
    end

    ////////////////////
    // per note gate and press pulse
    always_comb begin
        for (int n = 0; n < `SYN_NUM_NOTES; n++) begin
            key_events[n].gate = key_q[n];
            // high only in the first cycle of the gate
            key_events[n].trigger = key_q[n] & ~key_prev[n];
        end
    end

endmodule

`default_nettype wire

/* src/pdm_modulator.sv */
`timescale 1ns/1ps
`default_nettype none

`include "synth_config.svh"

module pdm_modulator (
    input wire logic clk_100mhz,
    input wire logic sys_rst,
    input wire mix_pkg::sample_t level,
    output logic pdm_out
);

    // carry in the top bit, residue below
    logic [`SYN_SAMPLE_W:0] acc;
    logic [`SYN_SAMPLE_W:0] acc_next;

    assign acc_next = acc[`SYN_SAMPLE_W-1:0] + level;

    // first order sigma delta, density of ones tracks level / 65536
    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            acc <= '0;
        end else begin
            acc <= acc_next;
        end
    end

    // registered carry is the speaker bit
    assign pdm_out = acc[`SYN_SAMPLE_W];

    assert property (@(posedge clk_100mhz) sys_rst |=> !pdm_out);

endmodule

`default_nettype wire

/* src/synth_config.svh */
`ifndef SYNTH_CONFIG_SVH
`define SYNTH_CONFIG_SVH

// keys and voices
`define SYN_NUM_NOTES 8

////////////////////
// datapath widths
`define SYN_SAMPLE_W 16
`define SYN_PHASE_W 24
`define SYN_ENV_W 16
`define SYN_TABLE_AW 8

////////////////////
// envelope levels and steps per clock
`define SYN_ENV_MAX 16'hFFFF
`define SYN_SUSTAIN_LEVEL 16'h4000
`define SYN_ATTACK_STEP 64
`define SYN_DECAY_STEP 32
`define SYN_RELEASE_STEP 64

// mixer normalization
`define SYN_RECIP_SHIFT 8
`define SYN_MAX_NORM_VOICES 8

`endif

/* src/synth_pkg.sv */
`default_nettype none

`include "synth_config.svh"

package synth_pkg;

    import mix_pkg::*;

    typedef logic [`SYN_NUM_NOTES-1:0] key_mask_t;

    // gate is the held level, trigger pulses on the press
    typedef struct packed {
        logic gate;
        logic trigger;
    } key_event_t;

    typedef logic [`SYN_ENV_W-1:0] env_t;
    typedef logic [`SYN_PHASE_W-1:0] phase_t;

    typedef enum logic [2:0] {
        ENV_IDLE,
        ENV_ATTACK,
        ENV_DECAY,
        ENV_SUSTAIN,
        ENV_RELEASE
    } env_state_e;

    typedef struct packed {
        logic sounding;
        sample_t sample;
    } voice_out_t;

    // just major scale, ratios x240, next octave doubles the step
    function automatic phase_t note_increment(input int unsigned note);
        int unsigned ratio;
        case (note % 8)
            0: ratio = 240;
            1: ratio = 270;
            2: ratio = 300;
            3: ratio = 320;
            4: ratio = 360;
            5: ratio = 400;
            6: ratio = 450;
            default: ratio = 480;
        endcase
        return phase_t'((ratio * 64) << (note / 8));
    endfunction

endpackage

`default_nettype wire

/* src/synth_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "synth_config.svh"

module synth_top (
    input wire logic clk_100mhz,
    input wire logic sys_rst,
    input wire synth_pkg::key_mask_t touch_status,
    output mix_pkg::mix_status_t line_sample,
    output logic pdm_out
);

    import synth_pkg::*;

    key_event_t key_events [`SYN_NUM_NOTES];
    voice_out_t voices [`SYN_NUM_NOTES];

    note_decoder u_decoder (
        .clk_100mhz(clk_100mhz),
        .sys_rst(sys_rst),
        .touch_status(touch_status),
        .key_events(key_events)
    );

    ////////////////////
    // one voice per key, upper half of the keyboard is saw
    for (genvar i = 0; i < `SYN_NUM_NOTES; i++) begin : g_voice
        voice_channel #(
            .NOTE_INDEX(i),
            .USE_SAW(i >= `SYN_NUM_NOTES / 2)
        ) u_voice (
            .clk_100mhz(clk_100mhz),
            .sys_rst(sys_rst),
            .key_event(key_events[i]),
            .voice(voices[i])
        );
    end

    voice_mixer u_mixer (
        .clk_100mhz(clk_100mhz),
        .sys_rst(sys_rst),
        .voices(voices),
        .line_sample(line_sample)
    );

    // speaker bit stream from the normalized mix
    pdm_modulator u_pdm (
        .clk_100mhz(clk_100mhz),
        .sys_rst(sys_rst),
        .level(line_sample.sample),
        .pdm_out(pdm_out)
    );

endmodule

`default_nettype wire

/* src/voice_channel.sv */
`timescale 1ns/1ps
`default_nettype none

`include "synth_config.svh"

module voice_channel #(
    parameter int NOTE_INDEX = 0,
    parameter bit USE_SAW = 1'b0
) (
    input wire logic clk_100mhz,
    input wire logic sys_rst,
    input wire synth_pkg::key_event_t key_event,
    output synth_pkg::voice_out_t voice
);

    import synth_pkg::*;
    import mix_pkg::*;

    localparam phase_t PHASE_STEP = note_increment(NOTE_INDEX);
    localparam int HALF_TABLE = 2 ** (`SYN_TABLE_AW - 1);

    phase_t phase;
    env_t envelope;
    logic sounding;
    sample_t wave;
    sample_t wave_q;
    env_t env_q;
    logic sounding_q;
    sample_t sample_q;
    logic [`SYN_SAMPLE_W+`SYN_ENV_W-1:0] product;

    // bhaskara approximation, exact at zero crossings and peaks
    function automatic sample_t sine_entry(input int unsigned idx);
        longint n;
        longint num;
        longint den;
        longint mag;
        n = idx % HALF_TABLE;
        num = 16 * n * (HALF_TABLE - n);
        den = 5 * HALF_TABLE * HALF_TABLE - 4 * n * (HALF_TABLE - n);
        mag = (32767 * num) / den;
        if (idx < HALF_TABLE) begin
            return sample_t'(32768 + mag);
        end
        return sample_t'(32768 - mag);
    endfunction

    adsr_envelope u_envelope (
        .clk_100mhz(clk_100mhz),
        .sys_rst(sys_rst),
        .key_event(key_event),
        .envelope(envelope),
        .sounding(sounding)
    );

    // phase runs only while held, press restarts the cycle
    always_ff @(posedge clk_100mhz) begin
        if (sys_rst || key_event.trigger) begin
            phase <= '0;
        end else if (key_event.gate) begin
            phase <= phase + PHASE_STEP;
        end
    end

    ////////////////////
    // waveform select
    generate
        if (USE_SAW) begin : g_saw
            // saw is the phase itself
            assign wave = phase[`SYN_PHASE_W-1 -: `SYN_SAMPLE_W];
        end else begin : g_sine
            sample_t sine_rom [2**`SYN_TABLE_AW];
            initial begin
                for (int i = 0; i < 2 ** `SYN_TABLE_AW; i++) begin
                    sine_rom[i] = sine_entry(i);
                end
            end
            assign wave = sine_rom[phase[`SYN_PHASE_W-1 -: `SYN_TABLE_AW]];
        end
    endgenerate

    // stage 1, wave and envelope side by side
    always_ff @(posedge clk_100mhz) begin
        wave_q <= wave;
        env_q <= envelope;
    end

    assign product = wave_q * env_q;

    // stage 2, scaled sample, zero when silent
    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            sounding_q <= 1'b0;
            sample_q <= '0;
        end else begin
            sounding_q <= sounding;
            sample_q <= sounding_q ? product[$high(product) -: `SYN_SAMPLE_W] : '0;
        end
    end

    // sounding leaves straight from the envelope FSM
    assign voice = '{sounding: sounding, sample: sample_q};

endmodule

`default_nettype wire

/* src/voice_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "synth_config.svh"

module voice_mixer (
    input wire logic clk_100mhz,
    input wire logic sys_rst,
    input wire synth_pkg::voice_out_t voices [`SYN_NUM_NOTES],
    output mix_pkg::mix_status_t line_sample
);

    import mix_pkg::*;

    localparam int NUM_PAIRS = `SYN_NUM_NOTES / 2;
    localparam int TOTAL_W = `SYN_SAMPLE_W + $clog2(`SYN_NUM_NOTES);

    logic [`SYN_SAMPLE_W:0] pair_sum [NUM_PAIRS];
    logic [`SYN_NUM_NOTES-1:0] sounding_q;
    logic [TOTAL_W-1:0] tree_sum;
    logic [TOTAL_W-1:0] total;
    voice_count_t count_q;
    logic [TOTAL_W+7:0] scaled;
    logic [TOTAL_W+7-`SYN_RECIP_SHIFT:0] shifted;

    ////////////////////
    // stage 1, pair sums and sounding bits
    always_ff @(posedge clk_100mhz) begin
        for (int p = 0; p < NUM_PAIRS; p++) begin
            pair_sum[p] <= voices[2*p].sample + voices[2*p+1].sample;
        end
    end

    always_comb begin
        tree_sum = '0;
        for (int p = 0; p < NUM_PAIRS; p++) begin
            tree_sum = tree_sum + pair_sum[p];
        end
    end

    // stage 2, full total
    always_ff @(posedge clk_100mhz) begin
        total <= tree_sum;
    end

    // count follows the sample path cycle for cycle
    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            sounding_q <= '0;
            count_q <= '0;
        end else begin
            for (int n = 0; n < `SYN_NUM_NOTES; n++) begin
                sounding_q[n] <= voices[n].sounding;
            end
            count_q <= voice_count_t'($countones(sounding_q));
        end
    end

    ////////////////////
    // stage 3, divide by voice count via reciprocal
    assign scaled = total * recip_factor(count_q);
    assign shifted = scaled[TOTAL_W+7:`SYN_RECIP_SHIFT];

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            line_sample <= '0;
        end else begin
            line_sample.voice_count <= count_q;
            // clip anything above full scale
            if (|shifted[$high(shifted):`SYN_SAMPLE_W]) begin
                line_sample.sample <= '1;
            end else begin
                line_sample.sample <= shifted[`SYN_SAMPLE_W-1:0];
            end
        end
    end

    assert property (@(posedge clk_100mhz) disable iff (sys_rst)
        line_sample.voice_count <= `SYN_NUM_NOTES);

endmodule

`default_nettype wire

/* tb.f */
+incdir+src
src/mix_pkg.sv
src/synth_pkg.sv
src/note_decoder.sv
src/adsr_envelope.sv
src/voice_channel.sv
src/voice_mixer.sv
src/pdm_modulator.sv
src/synth_top.sv
tb/tb_synth_top.sv

/* tb/tb_synth_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "synth_config.svh"

module tb_synth_top;

    import synth_pkg::*;
    import mix_pkg::*;

    // attack climbs the full range, decay drops to sustain
    localparam int ATTACK_CYCLES = 65536 / `SYN_ATTACK_STEP;
    localparam int DECAY_CYCLES = (65536 - `SYN_SUSTAIN_LEVEL) / `SYN_DECAY_STEP;
    localparam int SETTLE_MARGIN = 64;
    // largest sustained single voice after the 255/256 scaling
    localparam longint SUSTAIN_BOUND = 65535 * `SYN_SUSTAIN_LEVEL / 65536 * 255 / 256;

    logic clk_100mhz;
    logic sys_rst;
    key_mask_t touch_status;
    mix_status_t line_sample;
    logic pdm_out;
    logic [15:0] lfsr_state;

    synth_top u_dut (
        .clk_100mhz(clk_100mhz),
        .sys_rst(sys_rst),
        .touch_status(touch_status),
        .line_sample(line_sample),
        .pdm_out(pdm_out)
    );

    initial begin
        clk_100mhz = 1'b0;
        forever #5 clk_100mhz = ~clk_100mhz;
    end

    ////////////////////
    // helpers

    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_equal(input string name, input longint actual,
                               input longint expected);
        if (actual != expected) begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            stop_run();
        end
    endtask

    // one clock, then settle past the edge
    task automatic tick();
        @(posedge clk_100mhz);
        #1;
    endtask

    task automatic wait_for_count(input int expected, input int limit);
        int waited;
        waited = 0;
        while (line_sample.voice_count != expected) begin
            if (waited >= limit) begin
                $display("voice count did not reach %0d within %0d cycles", expected, limit);
                stop_run();
            end
            tick();
            waited++;
        end
    endtask

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic take_random_bits(input int width, output logic [31:0] bits);
        bits = '0;
        for (int b = 0; b < width; b++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic int count_keys(input key_mask_t mask);
        int total;
        total = 0;
        for (int n = 0; n < `SYN_NUM_NOTES; n++) begin
            total += mask[n];
        end
        return total;
    endfunction

    ////////////////////
    // directed tests

    task automatic reset_quiet_test();
        for (int c = 0; c < 100; c++) begin
            tick();
            check_equal("line_sample.voice_count", line_sample.voice_count, 0);
            check_equal("line_sample.sample", line_sample.sample, 0);
            check_equal("pdm_out", pdm_out, 0);
        end
    endtask

    // key 0 is a sine voice
    task automatic single_key_test();
        longint peak;
        peak = 0;
        touch_status = 8'b0000_0001;
        wait_for_count(1, 10);
        repeat (ATTACK_CYCLES + DECAY_CYCLES + SETTLE_MARGIN) tick();
        // more than one full sine period at sustain
        for (int c = 0; c < 2000; c++) begin
            tick();
            check_equal("line_sample.voice_count", line_sample.voice_count, 1);
            if (line_sample.sample > SUSTAIN_BOUND) begin
                check_equal("line_sample.sample", line_sample.sample, SUSTAIN_BOUND);
            end
            if (line_sample.sample > peak) begin
                peak = line_sample.sample;
            end
        end
        if (peak <= SUSTAIN_BOUND / 2) begin
            $display("sustained peak %0d is not above half of %0d", peak, SUSTAIN_BOUND);
            stop_run();
        end
    endtask

    task automatic release_test();
        touch_status = '0;
        wait_for_count(0, 1100);
        // sample path trails the count
        repeat (3) tick();
        for (int c = 0; c < 20; c++) begin
            check_equal("line_sample.sample", line_sample.sample, 0);
            check_equal("line_sample.voice_count", line_sample.voice_count, 0);
            tick();
        end
    endtask

    task automatic random_chord_test();
        logic [31:0] bits;
        key_mask_t mask;
        for (int round = 0; round < 3; round++) begin
            take_random_bits(8, bits);
            mask = key_mask_t'(bits);
            if (mask == '0) begin
                mask = 8'b0000_0001;
            end
            touch_status = mask;
            repeat (20) tick();
            check_equal("line_sample.voice_count", line_sample.voice_count, count_keys(mask));
            touch_status = '0;
            wait_for_count(0, 1100);
            repeat (3) tick();
            check_equal("line_sample.sample", line_sample.sample, 0);
        end
    endtask

    // two sines and one saw
    task automatic pdm_density_test();
        longint ones;
        longint level_sum;
        longint prev_level;
        longint diff;
        ones = 0;
        level_sum = 0;
        touch_status = 8'b0100_1001;
        wait_for_count(3, 10);
        repeat (ATTACK_CYCLES + DECAY_CYCLES + SETTLE_MARGIN) tick();
        prev_level = line_sample.sample;
        for (int c = 0; c < 4096; c++) begin
            tick();
            ones += pdm_out;
            // output bit lags its level by one clock
            level_sum += prev_level;
            prev_level = line_sample.sample;
        end
        if (level_sum == 0) begin
            $display("sustained chord produced no signal for the modulator");
            stop_run();
        end
        diff = ones * 65536 - level_sum;
        if (diff < 0) begin
            diff = -diff;
        end
        if (diff > 2 * 65536) begin
            check_equal("pdm_out ones x 65536", ones * 65536, level_sum);
        end
        touch_status = '0;
        wait_for_count(0, 1100);
    endtask

    ////////////////////
    // sequence

    initial begin
        sys_rst = 1'b1;
        touch_status = '0;
        lfsr_state = 16'd21459;
        repeat (8) @(posedge clk_100mhz);
        #1;
        sys_rst = 1'b0;
        reset_quiet_test();
        single_key_test();
        release_test();
        random_chord_test();
        pdm_density_test();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
